//--- rtl/qlsu_defs.svh
`ifndef QLSU_DEFS_SVH
`define QLSU_DEFS_SVH

// Matrix geometry
`define QLSU_LANES 4
`define QLSU_ROWS 4

// --------------------
// FP32 input format
`define QLSU_FP_W 32
`define QLSU_FP_EXP_W 8
`define QLSU_FP_MANT_W 23
`define QLSU_FP_BIAS 127

// Quantized lane
`define QLSU_Q_W 8
`define QLSU_Q_MAX 127

// --------------------
// Instruction fields
`define QLSU_INFO_W 16
`define QLSU_SCALE_W 5
`define QLSU_OPC_W 2
`define QLSU_OPC_READ 1
`define QLSU_OPC_WRITE 2

`endif

//--- rtl/qlsu_pkg.sv
`default_nettype none

`include "qlsu_defs.svh"

package qlsu_pkg;

  // Tensor data
  typedef logic [`QLSU_FP_W-1:0] fp_scalar_t;
  typedef logic [`QLSU_LANES*`QLSU_FP_W-1:0] fp_row_t;
  typedef logic [`QLSU_Q_W-1:0] q_scalar_t;
  typedef logic [`QLSU_LANES*`QLSU_Q_W-1:0] q_row_t;

  // Operation fields
  typedef logic signed [`QLSU_SCALE_W-1:0] scale_exp_t;
  typedef logic [`QLSU_INFO_W-1:0] matrix_info_t;
  // Scale on top, info below
  typedef logic [`QLSU_SCALE_W+`QLSU_INFO_W-1:0] op_inst_t;
  // Info on top, opcode below
  typedef logic [`QLSU_INFO_W+`QLSU_OPC_W-1:0] lsu_inst_t;

  typedef logic [$clog2(`QLSU_ROWS+1)-1:0] row_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    ISSUE_RD,
    LOAD,
    ISSUE_WR,
    STORE
  } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/qlsu_lane_quant.sv
`timescale 1ns/1ps
`default_nettype none

`include "qlsu_defs.svh"

module qlsu_lane_quant (
  input  wire qlsu_pkg::fp_scalar_t lane_i,
  input  wire qlsu_pkg::scale_exp_t scale_i,
  output qlsu_pkg::q_scalar_t       q_o
);

  import qlsu_pkg::*;

  localparam int KW = `QLSU_FP_EXP_W + 3;

  logic                       sign;
  logic [`QLSU_FP_EXP_W-1:0]  exp_f;
  logic [`QLSU_FP_MANT_W-1:0] mant;
  logic signed [KW-1:0]       k;
  logic [`QLSU_FP_MANT_W:0]   shifted;
  q_scalar_t                  mag;
  logic                       sat;

  assign sign  = lane_i[`QLSU_FP_W-1];
  assign exp_f = lane_i[`QLSU_FP_MANT_W +: `QLSU_FP_EXP_W];
  assign mant  = lane_i[`QLSU_FP_MANT_W-1:0];

  // Unbiased exponent after the power-of-two scale
  assign k = $signed({3'b000, exp_f}) - `QLSU_FP_BIAS + scale_i;

  always_comb begin
    mag     = '0;
    sat     = 1'b0;
    shifted = '0;
    if (exp_f == '0) begin
      // zero and denormals
      mag = '0;
    end else if (exp_f == '1) begin
      sat = 1'b1;
    end else if (k < 0) begin
      mag = '0;
    end else if (k >= `QLSU_Q_W - 1) begin
      sat = 1'b1;
    end else begin
      // Keep the top k+1 bits, truncating toward zero
      shifted = {1'b1, mant} >> (`QLSU_FP_MANT_W - k);
      mag     = shifted[`QLSU_Q_W-1:0];
    end
    if (sat) begin
      mag = `QLSU_Q_MAX;
    end
    q_o = sign ? -mag : mag;
  end

endmodule

`default_nettype wire

//--- rtl/qlsu_row_quantizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "qlsu_defs.svh"

module qlsu_row_quantizer (
  input  wire                    clk,
  input  wire                    rstnn,
  input  wire                    in_valid_i,
  output logic                   in_ready_o,
  input  wire qlsu_pkg::fp_row_t in_row_i,
  input  wire qlsu_pkg::scale_exp_t scale_i,
  output logic                   out_valid_o,
  input  wire                    out_ready_i,
  output qlsu_pkg::q_row_t       out_row_o
);

  import qlsu_pkg::*;

  logic    s1_valid;
  fp_row_t s1_row;
  logic    s2_valid;
  q_row_t  s2_row;
  q_row_t  conv_row;
  logic    s2_adv;

  // Stage 2 moves when empty or drained
  assign s2_adv     = !s2_valid || out_ready_i;
  assign in_ready_o = !s1_valid || s2_adv;

  // --------------------
  // Lane converters
  for (genvar lane = 0; lane < `QLSU_LANES; lane++) begin : g_lane
    qlsu_lane_quant lane_quant_inst (
      .lane_i  (s1_row[lane*`QLSU_FP_W +: `QLSU_FP_W]),
      .scale_i (scale_i),
      .q_o     (conv_row[lane*`QLSU_Q_W +: `QLSU_Q_W])
    );
  end

  // --------------------
  // Stage valids
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (in_ready_o) begin
        s1_valid <= in_valid_i;
      end
      if (s2_adv) begin
        s2_valid <= s1_valid;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (in_ready_o && in_valid_i) begin
      s1_row <= in_row_i;
    end
    if (s2_adv && s1_valid) begin
      s2_row <= conv_row;
    end
  end

  assign out_valid_o = s2_valid;
  assign out_row_o   = s2_row;

endmodule

`default_nettype wire

//--- rtl/qlsu_quant_mreg.sv
`timescale 1ns/1ps
`default_nettype none

`include "qlsu_defs.svh"

module qlsu_quant_mreg (
  input  wire                   clk,
  input  wire                   rstnn,
  input  wire                   start_i,
  input  wire                   wr_valid_i,
  output logic                  wr_ready_o,
  input  wire qlsu_pkg::q_row_t wr_row_i,
  output logic                  full_o,
  input  wire                   store_enable_i,
  output logic                  store_done_o,
  input  wire                   sstore_row_valid_i,
  input  wire                   sstore_row_last_i,
  output logic                  sstore_row_ready_o,
  output qlsu_pkg::q_row_t      sstore_row_data_o
);

  import qlsu_pkg::*;

  localparam int IDX_W = $clog2(`QLSU_ROWS);

  q_row_t   mem [`QLSU_ROWS];
  row_cnt_t wr_ptr;
  row_cnt_t rd_ptr;
  logic     wr_fire;
  logic     store_fire;

  // Never holds more rows than one operation loads
  assign wr_ready_o = 1'b1;
  assign wr_fire    = wr_valid_i & wr_ready_o;
  assign full_o     = (wr_ptr == `QLSU_ROWS);

  // --------------------
  // Write side
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr[IDX_W-1:0]] <= wr_row_i;
    end
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      wr_ptr <= '0;
    end else if (start_i) begin
      wr_ptr <= '0;
    end else if (wr_fire) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // --------------------
  // Store read-out, in write order
  assign sstore_row_ready_o = store_enable_i;
  assign sstore_row_data_o  = mem[rd_ptr[IDX_W-1:0]];
  assign store_fire         = sstore_row_valid_i & sstore_row_ready_o;
  assign store_done_o       = store_fire & sstore_row_last_i;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      rd_ptr <= '0;
    end else if (start_i) begin
      rd_ptr <= '0;
    end else if (store_fire) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!rstnn)
    wr_valid_i |-> !full_o
  );

  // LSU last flag must line up with the final stored row
  a_last_on_final_row: assert property (
    @(posedge clk) disable iff (!rstnn)
    store_fire |-> (sstore_row_last_i == (rd_ptr == `QLSU_ROWS - 1))
  );

endmodule

`default_nettype wire

//--- rtl/qlsu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "qlsu_defs.svh"

module qlsu_sequencer (
  input  wire                   clk,
  input  wire                   rstnn,
  input  wire                   inst_valid_i,
  input  wire qlsu_pkg::op_inst_t inst_data_i,
  output logic                  inst_ready_o,
  output logic                  operation_finish_o,
  output logic                  lsu_inst_valid_o,
  output qlsu_pkg::lsu_inst_t   lsu_inst_data_o,
  input  wire                   lsu_inst_ready_i,
  input  wire                   sload_row_valid_i,
  output logic                  sload_row_ready_o,
  output logic                  q_in_valid_o,
  input  wire                   q_in_ready_i,
  output qlsu_pkg::scale_exp_t  scale_o,
  output logic                  mreg_start_o,
  input  wire                   mreg_full_i,
  output logic                  store_enable_o,
  input  wire                   store_done_i
);

  import qlsu_pkg::*;

  localparam logic [`QLSU_OPC_W-1:0] OPC_READ = `QLSU_OPC_READ;
  localparam logic [`QLSU_OPC_W-1:0] OPC_WRITE = `QLSU_OPC_WRITE;

  seq_state_t   state;
  seq_state_t   state_nxt;
  op_inst_t     op_q;
  matrix_info_t info;
  row_cnt_t     row_cnt;
  logic         lsu_fire;
  logic         load_open;
  logic         load_fire;

  assign info    = op_q[`QLSU_INFO_W-1:0];
  assign scale_o = op_q[`QLSU_INFO_W +: `QLSU_SCALE_W];

  // --------------------
  // Operation FSM
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:     if (inst_valid_i) state_nxt = ISSUE_RD;
      ISSUE_RD: if (lsu_fire) state_nxt = LOAD;
      LOAD:     if (mreg_full_i) state_nxt = ISSUE_WR;
      ISSUE_WR: if (lsu_fire) state_nxt = STORE;
      STORE:    if (store_done_i) state_nxt = IDLE;
      default:  state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Word stays queued until the store ends
  always_ff @(posedge clk) begin
    if (state == IDLE && inst_valid_i) begin
      op_q <= inst_data_i;
    end
  end

  // --------------------
  // LSU instruction
  assign lsu_inst_valid_o = (state == ISSUE_RD) || (state == ISSUE_WR);
  assign lsu_inst_data_o  = {info, (state == ISSUE_WR) ? OPC_WRITE : OPC_READ};
  assign lsu_fire         = lsu_inst_valid_o & lsu_inst_ready_i;

  // Clear the matrix register on the edge into LOAD
  assign mreg_start_o = (state == ISSUE_RD) & lsu_fire;

  // --------------------
  // Load gating
  assign load_open         = (state == LOAD) && (row_cnt < `QLSU_ROWS);
  assign sload_row_ready_o = load_open & q_in_ready_i;
  assign q_in_valid_o      = load_open & sload_row_valid_i;
  assign load_fire         = sload_row_valid_i & sload_row_ready_o;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      row_cnt <= '0;
    end else if (mreg_start_o) begin
      row_cnt <= '0;
    end else if (load_fire) begin
      row_cnt <= row_cnt + 1'b1;
    end
  end

  // Store and completion
  assign store_enable_o     = (state == STORE);
  assign inst_ready_o       = (state == STORE) & store_done_i;
  assign operation_finish_o = (state == IDLE);

  a_lsu_inst_stable: assert property (
    @(posedge clk) disable iff (!rstnn)
    lsu_inst_valid_o && !lsu_inst_ready_i |=> lsu_inst_valid_o && $stable(lsu_inst_data_o)
  );

endmodule

`default_nettype wire

//--- rtl/qlsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module qlsu_top (
  input  wire                     clk,
  input  wire                     rstnn,
  input  wire                     inst_valid_i,
  input  wire qlsu_pkg::op_inst_t inst_data_i,
  output logic                    inst_ready_o,
  output logic                    operation_finish_o,
  output logic                    lsu_inst_valid_o,
  output qlsu_pkg::lsu_inst_t     lsu_inst_data_o,
  input  wire                     lsu_inst_ready_i,
  input  wire                     sload_row_valid_i,
  input  wire qlsu_pkg::fp_row_t  sload_row_data_i,
  output logic                    sload_row_ready_o,
  input  wire                     sstore_row_valid_i,
  input  wire                     sstore_row_last_i,
  output logic                    sstore_row_ready_o,
  output qlsu_pkg::q_row_t        sstore_row_data_o
);

  import qlsu_pkg::*;

  logic       q_in_valid;
  logic       q_in_ready;
  scale_exp_t scale;
  logic       q_out_valid;
  logic       q_out_ready;
  q_row_t     q_out_row;
  logic       mreg_start;
  logic       mreg_full;
  logic       store_enable;
  logic       store_done;

  qlsu_sequencer qlsu_sequencer_inst (
    .clk                (clk),
    .rstnn              (rstnn),
    .inst_valid_i       (inst_valid_i),
    .inst_data_i        (inst_data_i),
    .inst_ready_o       (inst_ready_o),
    .operation_finish_o (operation_finish_o),
    .lsu_inst_valid_o   (lsu_inst_valid_o),
    .lsu_inst_data_o    (lsu_inst_data_o),
    .lsu_inst_ready_i   (lsu_inst_ready_i),
    .sload_row_valid_i  (sload_row_valid_i),
    .sload_row_ready_o  (sload_row_ready_o),
    .q_in_valid_o       (q_in_valid),
    .q_in_ready_i       (q_in_ready),
    .scale_o            (scale),
    .mreg_start_o       (mreg_start),
    .mreg_full_i        (mreg_full),
    .store_enable_o     (store_enable),
    .store_done_i       (store_done)
  );

  // Load rows go straight in, gated by the sequencer
  qlsu_row_quantizer qlsu_row_quantizer_inst (
    .clk         (clk),
    .rstnn       (rstnn),
    .in_valid_i  (q_in_valid),
    .in_ready_o  (q_in_ready),
    .in_row_i    (sload_row_data_i),
    .scale_i     (scale),
    .out_valid_o (q_out_valid),
    .out_ready_i (q_out_ready),
    .out_row_o   (q_out_row)
  );

  qlsu_quant_mreg qlsu_quant_mreg_inst (
    .clk                (clk),
    .rstnn              (rstnn),
    .start_i            (mreg_start),
    .wr_valid_i         (q_out_valid),
    .wr_ready_o         (q_out_ready),
    .wr_row_i           (q_out_row),
    .full_o             (mreg_full),
    .store_enable_i     (store_enable),
    .store_done_o       (store_done),
    .sstore_row_valid_i (sstore_row_valid_i),
    .sstore_row_last_i  (sstore_row_last_i),
    .sstore_row_ready_o (sstore_row_ready_o),
    .sstore_row_data_o  (sstore_row_data_o)
  );

endmodule

`default_nettype wire

//--- tests/qlsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "qlsu_defs.svh"

module qlsu_tb;

  import qlsu_pkg::*;

  localparam int NUM_TESTS = 4;
  localparam int NUM_VALS = `QLSU_ROWS * `QLSU_LANES;
  localparam int TIMEOUT_CYCLES = 200 * NUM_TESTS + 20;

  logic      clk;
  logic      rstnn;
  logic      inst_valid_i;
  op_inst_t  inst_data_i;
  logic      inst_ready_o;
  logic      operation_finish_o;
  logic      lsu_inst_valid_o;
  lsu_inst_t lsu_inst_data_o;
  logic      lsu_inst_ready_i;
  logic      sload_row_valid_i;
  fp_row_t   sload_row_data_i;
  logic      sload_row_ready_o;
  logic      sstore_row_valid_i;
  logic      sstore_row_last_i;
  logic      sstore_row_ready_o;
  q_row_t    sstore_row_data_o;

  // Operation table
  string                    name_tab [NUM_TESTS];
  logic [`QLSU_INFO_W-1:0]  info_tab [NUM_TESTS];
  logic [`QLSU_SCALE_W-1:0] scale_tab [NUM_TESTS];
  logic [`QLSU_FP_W-1:0]    fp_tab [NUM_TESTS][NUM_VALS];
  logic [`QLSU_Q_W-1:0]     q_tab [NUM_TESTS][NUM_VALS];

  logic [7:0] lfsr_state = 8'd33;
  string      cur_name = "reset";
  int         cycle_cnt = 0;
  int         load_cnt = 0;
  int         pulse_cnt = 0;
  logic       busy = 1'b0;

  qlsu_top qlsu_top_inst (
    .clk                (clk),
    .rstnn              (rstnn),
    .inst_valid_i       (inst_valid_i),
    .inst_data_i        (inst_data_i),
    .inst_ready_o       (inst_ready_o),
    .operation_finish_o (operation_finish_o),
    .lsu_inst_valid_o   (lsu_inst_valid_o),
    .lsu_inst_data_o    (lsu_inst_data_o),
    .lsu_inst_ready_i   (lsu_inst_ready_i),
    .sload_row_valid_i  (sload_row_valid_i),
    .sload_row_data_i   (sload_row_data_i),
    .sload_row_ready_o  (sload_row_ready_o),
    .sstore_row_valid_i (sstore_row_valid_i),
    .sstore_row_last_i  (sstore_row_last_i),
    .sstore_row_ready_o (sstore_row_ready_o),
    .sstore_row_data_o  (sstore_row_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Helpers
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Mismatch %s: expected %0h, actual %0h", what, expected, actual));
    end
  endtask

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | lfsr_state[0];
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic random_gap();
    int gap;
    take_bits(2, gap);
    repeat (gap) next_cycle();
  endtask

  task automatic check_reset_outputs(input string when);
    check_value({when, " inst_ready_o"}, 1'b0, inst_ready_o);
    check_value({when, " lsu_inst_valid_o"}, 1'b0, lsu_inst_valid_o);
    check_value({when, " sload_row_ready_o"}, 1'b0, sload_row_ready_o);
    check_value({when, " sstore_row_ready_o"}, 1'b0, sstore_row_ready_o);
    check_value({when, " operation_finish_o"}, 1'b1, operation_finish_o);
  endtask

  // --------------------
  // LSU model
  task automatic accept_lsu_inst(input int e, input logic [`QLSU_OPC_W-1:0] opc);
    logic fire;
    do begin
      @(negedge clk);
      fire = lsu_inst_valid_o;
      next_cycle();
    end while (!fire);
    random_gap();
    lsu_inst_ready_i = 1'b1;
    do begin
      @(negedge clk);
      fire = lsu_inst_valid_o;
      if (fire) begin
        check_value($sformatf("%s lsu inst", name_tab[e]), {info_tab[e], opc}, lsu_inst_data_o);
      end
      next_cycle();
    end while (!fire);
    lsu_inst_ready_i = 1'b0;
  endtask

  task automatic feed_rows(input int e);
    logic    fire;
    fp_row_t row;
    for (int r = 0; r < `QLSU_ROWS; r++) begin
      random_gap();
      for (int l = 0; l < `QLSU_LANES; l++) begin
        row[l*`QLSU_FP_W +: `QLSU_FP_W] = fp_tab[e][r*`QLSU_LANES + l];
      end
      sload_row_valid_i = 1'b1;
      sload_row_data_i  = row;
      do begin
        @(negedge clk);
        fire = sload_row_ready_o;
        next_cycle();
      end while (!fire);
      sload_row_valid_i = 1'b0;
    end
    // Spare row past the fourth stays refused
    sload_row_valid_i = 1'b1;
    sload_row_data_i  = '1;
  endtask

  task automatic drain_rows(input int e);
    logic   fire;
    q_row_t row;
    for (int r = 0; r < `QLSU_ROWS; r++) begin
      random_gap();
      for (int l = 0; l < `QLSU_LANES; l++) begin
        row[l*`QLSU_Q_W +: `QLSU_Q_W] = q_tab[e][r*`QLSU_LANES + l];
      end
      sstore_row_valid_i = 1'b1;
      sstore_row_last_i  = (r == `QLSU_ROWS - 1);
      do begin
        @(negedge clk);
        fire = sstore_row_ready_o;
        if (fire) begin
          check_value($sformatf("%s store row %0d", name_tab[e], r), row, sstore_row_data_o);
          check_value({name_tab[e], " inst_ready_o"}, sstore_row_last_i, inst_ready_o);
        end
        next_cycle();
      end while (!fire);
      sstore_row_valid_i = 1'b0;
      sstore_row_last_i  = 1'b0;
    end
    // Operation ends with the last store row
    busy = 1'b0;
  endtask

  // --------------------
  // Stimulus table
  task automatic set_header(input int e, input string name, input logic [15:0] info,
                            input logic [4:0] scale);
    name_tab[e]  = name;
    info_tab[e]  = info;
    scale_tab[e] = scale;
  endtask

  task automatic fill_table();
    set_header(0, "in_range", 16'h1a2b, 5'd2);
    fp_tab[0] = '{32'h3fc00000, 32'hc0300000, 32'h3ecccccd, 32'h3e800000,
                  32'hbe4ccccd, 32'h40400000, 32'hbf800000, 32'h41280000,
                  32'h41fe0000, 32'hc1a00000, 32'h3e000000, 32'h40a00000,
                  32'hbf000000, 32'h40200000, 32'hc0e00000, 32'h3f400000};
    q_tab[0] = '{8'h06, 8'hf5, 8'h01, 8'h01, 8'h00, 8'h0c, 8'hfc, 8'h2a,
                 8'h7f, 8'hb0, 8'h00, 8'h14, 8'hfe, 8'h0a, 8'he4, 8'h03};
    set_header(1, "scale_zero", 16'h00c4, 5'd0);
    fp_tab[1] = '{32'hc0300000, 32'h3ecccccd, 32'h3fc00000, 32'h42c80000,
                  32'hc2c80000, 32'h42fe0000, 32'hc2ff0000, 32'h3f7fffff,
                  32'h3f800000, 32'hbf800000, 32'h427e0000, 32'hc0d00000,
                  32'h40000000, 32'hbf400000, 32'h41440000, 32'hc0400000};
    q_tab[1] = '{8'hfe, 8'h00, 8'h01, 8'h64, 8'h9c, 8'h7f, 8'h81, 8'h00,
                 8'h01, 8'hff, 8'h3f, 8'hfa, 8'h02, 8'h00, 8'h0c, 8'hfd};
    set_header(2, "saturate_special", 16'hbeef, 5'd3);
    fp_tab[2] = '{32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h00000000,
                  32'h80000000, 32'h00000001, 32'h807fffff, 32'h41800000,
                  32'hc1800000, 32'h417f0000, 32'h49742400, 32'hff7fffff,
                  32'h3f800000, 32'hbe000000, 32'h3d800000, 32'h00800000};
    q_tab[2] = '{8'h7f, 8'h81, 8'h7f, 8'h00, 8'h00, 8'h00, 8'h00, 8'h7f,
                 8'h81, 8'h7f, 8'h7f, 8'h81, 8'h08, 8'hff, 8'h00, 8'h00};
    // Scale of -4
    set_header(3, "scale_negative", 16'h7001, 5'h1c);
    fp_tab[3] = '{32'h42000000, 32'hc2400000, 32'h41700000, 32'h41800000,
                  32'h447a0000, 32'hc4fe0000, 32'h45000000, 32'hc2c80000,
                  32'h3f800000, 32'hbf000000, 32'h43480000, 32'h42800000,
                  32'hc4800000, 32'h437f0000, 32'h7f800000, 32'hc0400000};
    q_tab[3] = '{8'h02, 8'hfd, 8'h00, 8'h01, 8'h3e, 8'h81, 8'h7f, 8'hfa,
                 8'h00, 8'h00, 8'h0c, 8'h04, 8'hc0, 8'h0f, 8'h7f, 8'h00};
  endtask

  // --------------------
  // Monitors
  always @(negedge clk) begin
    if (rstnn) begin
      check_value({cur_name, " operation_finish_o"}, !busy, operation_finish_o);
      if (inst_ready_o) begin
        pulse_cnt++;
      end
      if (sload_row_valid_i && sload_row_ready_o) begin
        load_cnt++;
      end
      // Busy from acceptance until the last store row
      if (!busy && inst_valid_i) begin
        busy = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    rstnn              = 1'b0;
    inst_valid_i       = 1'b0;
    inst_data_i        = '0;
    lsu_inst_ready_i   = 1'b0;
    sload_row_valid_i  = 1'b0;
    sload_row_data_i   = '0;
    sstore_row_valid_i = 1'b0;
    sstore_row_last_i  = 1'b0;
    fill_table();

    @(posedge clk);
    @(negedge clk);
    check_reset_outputs("during reset");
    next_cycle();
    rstnn = 1'b1;
    @(negedge clk);
    check_reset_outputs("after reset");
    next_cycle();

    for (int e = 0; e < NUM_TESTS; e++) begin
      cur_name     = name_tab[e];
      inst_valid_i = 1'b1;
      inst_data_i  = {scale_tab[e], info_tab[e]};
      accept_lsu_inst(e, `QLSU_OPC_READ);
      feed_rows(e);
      accept_lsu_inst(e, `QLSU_OPC_WRITE);
      sload_row_valid_i = 1'b0;
      drain_rows(e);
      // Word popped on the last store row
      if (e == NUM_TESTS - 1) begin
        inst_valid_i = 1'b0;
      end
      check_value({cur_name, " ready pulses"}, e + 1, pulse_cnt);
      check_value({cur_name, " rows loaded"}, `QLSU_ROWS * (e + 1), load_cnt);
    end

    repeat (4) next_cycle();
    check_value("final ready pulses", NUM_TESTS, pulse_cnt);
    check_value("final rows loaded", `QLSU_ROWS * NUM_TESTS, load_cnt);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/qlsu_pkg.sv
rtl/qlsu_lane_quant.sv
rtl/qlsu_row_quantizer.sv
rtl/qlsu_quant_mreg.sv
rtl/qlsu_sequencer.sv
rtl/qlsu_top.sv
tests/qlsu_tb.sv
